// ==== sim.f ====
+incdir+sim
verilog/elevator_pkg.sv
verilog/request_register.sv
verilog/floor_queue.sv
verilog/car_command_unit.sv
verilog/elevator_request_top.sv
sim/tb_elevator_request_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the elevator request testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module tb_elevator_request_top \
    -Mdir "$BUILD_DIR" \
    -f sim.f

"./$BUILD_DIR/Vtb_elevator_request_top" > "$LOG_FILE" 2>&1
cat "$LOG_FILE"

if grep -q "SIMULATION FAILED" "$LOG_FILE"; then
    echo "Failure reported, see $LOG_FILE"
    exit 1
fi
exit 0

// ==== sim/tb_scenarios.svh ====
`ifndef TB_SCENARIOS_SVH
`define TB_SCENARIOS_SVH

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic single_request_trip();
    int errors_at_start;
    errors_at_start = error_count;
    place_car(5);
    press('0, one_floor(8));
    ride_until_idle(100);
    // Now a trip downward
    press(one_floor(2), '0);
    ride_until_idle(100);
    finish_test("single request", errors_at_start);
endtask

task automatic duplicate_presses();
    int errors_at_start;
    errors_at_start = error_count;
    place_car(3);
    press(one_floor(3), one_floor(3));
    press(one_floor(7), '0);
    press(one_floor(7), one_floor(7));
    press('0, one_floor(7));
    press(one_floor(1), one_floor(7));
    ride_until_idle(150);
    finish_test("duplicate presses", errors_at_start);
endtask

task automatic press_order_service();
    int errors_at_start;
    errors_at_start = error_count;
    place_car(4);
    press('0, one_floor(9));
    press(one_floor(1), '0);
    press('0, one_floor(6));
    // Same two floors twice, lower one is taken first
    press(one_floor(10), one_floor(0));
    press(one_floor(10), one_floor(0));
    ride_until_idle(300);
    finish_test("press order", errors_at_start);
endtask

task automatic flush_and_recovery();
    int errors_at_start;
    errors_at_start = error_count;
    place_car(2);
    press('0, one_floor(8));
    press(one_floor(5), '0);
    emergency        = 1'b1;
    car_status.phase = PHASE_EMERGENCY;
    press(one_floor(6), one_floor(9));
    repeat (3) @(negedge clock);
    emergency        = 1'b0;
    car_status.phase = PHASE_STOPPED;
    press('0, one_floor(0));
    ride_until_idle(100);
    press(one_floor(7), one_floor(4));
    power_on = 1'b0;
    press(one_floor(3), '0);
    repeat (3) @(negedge clock);
    power_on = 1'b1;
    press('0, one_floor(9));
    ride_until_idle(120);
    finish_test("emergency and power off", errors_at_start);
endtask

task automatic door_grant_rules();
    int errors_at_start;
    errors_at_start = error_count;
    place_car(4);
    door_open_button = 1'b1;
    repeat (2) @(negedge clock);
    door_close_button = 1'b1;
    repeat (2) @(negedge clock);
    car_status.phase = PHASE_UP;
    repeat (2) @(negedge clock);
    car_status.phase = PHASE_EMERGENCY;
    emergency        = 1'b1;
    repeat (2) @(negedge clock);
    emergency        = 1'b0;
    car_status.phase = PHASE_STOPPED;
    power_on         = 1'b0;
    repeat (2) @(negedge clock);
    power_on = 1'b1;
    repeat (2) @(negedge clock);
    door_open_button  = 1'b0;
    door_close_button = 1'b0;
    @(negedge clock);
    finish_test("door grants", errors_at_start);
endtask

////////////////////////////////////////
// Random traffic
////////////////////////////////////////

task automatic random_traffic();
    int errors_at_start;
    int start;
    errors_at_start = error_count;
    place_car(0);
    random_presses = 1'b1;
    start          = cycle_count;
    while (cycle_count - start < RANDOM_CYCLES) begin
        if (command.activate) begin
            travel_to_target();
        end else begin
            next_cycle();
        end
    end
    random_presses = 1'b0;
    ride_until_idle(600);
    finish_test("random traffic", errors_at_start);
endtask

`endif

// ==== sim/tb_elevator_request_top.sv ====
`timescale 1ns/1ns

module tb_elevator_request_top;

    import elevator_pkg::*;

    localparam int NUM_FLOORS    = 11;
    localparam int CLOCK_PERIOD  = 40;
    localparam int STEP_CYCLES   = 3;
    localparam int SEED          = 52714;
    localparam int RANDOM_CYCLES = 500;
    // Worst case length of each test in cycles, doubled for the run limit
    localparam int TEST_CYCLES   = 5 + 220 + 170 + 320 + 260 + 20 + RANDOM_CYCLES + 600;
    localparam int CYCLE_LIMIT   = 2 * TEST_CYCLES;

    logic                  clock;
    logic                  reset_n;
    logic [NUM_FLOORS-1:0] call_buttons;
    logic [NUM_FLOORS-1:0] panel_buttons;
    logic                  door_open_button;
    logic                  door_close_button;
    logic                  emergency;
    logic                  power_on;
    car_status_t           car_status;
    logic [NUM_FLOORS-1:0] call_lamps;
    logic [NUM_FLOORS-1:0] panel_lamps;
    car_command_t          command;
    logic                  door_open_allowed;
    logic                  door_close_allowed;

    int   cycle_count = 0;
    int   error_count = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    logic random_presses;

    elevator_request_top #(
        .NUM_FLOORS (NUM_FLOORS)
    ) elevator_request_top_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .call_buttons       (call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency          (emergency),
        .power_on           (power_on),
        .car_status         (car_status),
        .call_lamps         (call_lamps),
        .panel_lamps        (panel_lamps),
        .command            (command),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    logic [NUM_FLOORS-1:0] exp_call, exp_panel, next_call, next_panel;
    int                    exp_q [NUM_FLOORS];
    int                    next_q [NUM_FLOORS];
    int                    exp_count, next_count;
    logic                  pend_valid, next_pend_valid;
    int                    pend_floor, next_pend_floor;
    logic                  model_flush, model_stopped, served, pick_found;
    int                    pick, current;
    car_command_t          exp_command;
    logic                  exp_door_open, exp_door_close;

    assign model_flush   = !power_on || emergency;
    assign model_stopped = is_stopped(car_status.phase);
    assign current       = int'(car_status.floor);

    always_comb begin
        next_call       = exp_call;
        next_panel      = exp_panel;
        next_q          = exp_q;
        next_count      = exp_count;
        next_pend_valid = 1'b0;
        next_pend_floor = 0;
        pick_found      = 1'b0;
        pick            = 0;
        served          = model_stopped && exp_count > 0 && exp_q[0] == current;
        if (model_flush) begin
            next_call  = '0;
            next_panel = '0;
            next_count = 0;
        end else begin
            if (served) begin
                for (int i = 0; i < NUM_FLOORS - 1; i++) begin
                    next_q[i] = exp_q[i + 1];
                end
                next_count = exp_count - 1;
            end
            // The floor accepted last cycle reaches the tail one edge later
            if (pend_valid && next_count < NUM_FLOORS) begin
                next_q[next_count] = pend_floor;
                next_count         = next_count + 1;
            end
            for (int f = 0; f < NUM_FLOORS; f++) begin
                if (!pick_found && (call_buttons[f] || panel_buttons[f])
                        && !exp_call[f] && !exp_panel[f] && f != current) begin
                    pick_found = 1'b1;
                    pick       = f;
                end
            end
            for (int f = 0; f < NUM_FLOORS; f++) begin
                if (exp_call[f] || exp_panel[f] || (pick_found && pick == f)) begin
                    next_call[f]  = exp_call[f] || call_buttons[f];
                    next_panel[f] = exp_panel[f] || panel_buttons[f];
                end
            end
            if (served) begin
                next_call[current]  = 1'b0;
                next_panel[current] = 1'b0;
            end
            next_pend_valid = pick_found;
            next_pend_floor = pick;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            exp_call   <= '0;
            exp_panel  <= '0;
            exp_count  <= 0;
            pend_valid <= 1'b0;
            pend_floor <= 0;
        end else begin
            exp_call   <= next_call;
            exp_panel  <= next_panel;
            exp_q      <= next_q;
            exp_count  <= next_count;
            pend_valid <= next_pend_valid;
            pend_floor <= next_pend_floor;
        end
    end

    always_comb begin
        exp_command = '0;
        if (!model_flush && model_stopped && exp_count > 0 && exp_q[0] != current) begin
            exp_command.activate = 1'b1;
            exp_command.up       = exp_q[0] > current;
            exp_command.target   = floor_t'(exp_q[0]);
        end
    end

    assign exp_door_open  = door_open_button && model_stopped && power_on;
    assign exp_door_close = door_close_button && model_stopped && power_on;

    ////////////////////////////////////////
    // Checks and helpers
    ////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        error_count++;
        $display("Error: %0t ns %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    endtask

    check_call_lamps: assert property (@(posedge clock) disable iff (!reset_n)
        call_lamps == exp_call
    ) else report_mismatch("call_lamps", 16'($sampled(exp_call)), 16'($sampled(call_lamps)));

    check_panel_lamps: assert property (@(posedge clock) disable iff (!reset_n)
        panel_lamps == exp_panel
    ) else report_mismatch("panel_lamps", 16'($sampled(exp_panel)), 16'($sampled(panel_lamps)));

    check_command: assert property (@(posedge clock) disable iff (!reset_n)
        command == exp_command
    ) else report_mismatch("command", 16'($sampled(exp_command)), 16'($sampled(command)));

    check_door_open: assert property (@(posedge clock) disable iff (!reset_n)
        door_open_allowed == exp_door_open
    ) else report_mismatch("door_open_allowed", 16'($sampled(exp_door_open)),
                           16'($sampled(door_open_allowed)));

    check_door_close: assert property (@(posedge clock) disable iff (!reset_n)
        door_close_allowed == exp_door_close
    ) else report_mismatch("door_close_allowed", 16'($sampled(exp_door_close)),
                           16'($sampled(door_close_allowed)));

    // Guard against a run that never finishes
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the tests", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [NUM_FLOORS-1:0] one_floor(input int f);
        logic [NUM_FLOORS-1:0] mask;
        mask    = '0;
        mask[f] = 1'b1;
        return mask;
    endfunction

    function automatic logic [NUM_FLOORS-1:0] random_mask();
        logic [NUM_FLOORS-1:0] mask;
        int                    idx;
        mask = '0;
        idx  = int'($urandom_range(NUM_FLOORS - 1));
        if ($urandom_range(3) == 0) begin
            mask[idx] = 1'b1;
        end
        return mask;
    endfunction

    // One cycle, with random presses while the random test runs
    task automatic next_cycle();
        @(negedge clock);
        call_buttons  = random_presses ? random_mask() : '0;
        panel_buttons = random_presses ? random_mask() : '0;
    endtask

    task automatic press(input logic [NUM_FLOORS-1:0] calls, input logic [NUM_FLOORS-1:0] panels);
        @(negedge clock);
        call_buttons  = calls;
        panel_buttons = panels;
        @(negedge clock);
        call_buttons  = '0;
        panel_buttons = '0;
    endtask

    task automatic place_car(input int f);
        @(negedge clock);
        car_status.floor = floor_t'(f);
        car_status.phase = PHASE_STOPPED;
    endtask

    // The car moves one floor every STEP_CYCLES toward the commanded floor
    task automatic travel_to_target();
        floor_t target;
        logic   going_up;
        target           = command.target;
        going_up         = target > car_status.floor;
        car_status.phase = going_up ? PHASE_UP : PHASE_DOWN;
        while (car_status.floor != target) begin
            repeat (STEP_CYCLES) next_cycle();
            if (going_up) begin
                car_status.floor = car_status.floor + floor_t'(1);
            end else begin
                car_status.floor = car_status.floor - floor_t'(1);
            end
        end
        car_status.phase = PHASE_STOPPED;
    endtask

    task automatic ride_until_idle(input int limit);
        int start;
        start = cycle_count;
        next_cycle();
        while ((call_lamps | panel_lamps) != '0) begin
            if (cycle_count - start > limit) begin
                error_count++;
                $display("Requests still pending %0d cycles after the last press", limit);
                return;
            end
            if (command.activate) begin
                travel_to_target();
            end else begin
                next_cycle();
            end
        end
        next_cycle();
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    `include "tb_scenarios.svh"

    initial begin
        void'($urandom(SEED));
        reset_n           = 1'b0;
        call_buttons      = '0;
        panel_buttons     = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power_on          = 1'b1;
        car_status        = '0;
        random_presses    = 1'b0;
        repeat (5) @(negedge clock);
        reset_n = 1'b1;

        single_request_trip();
        duplicate_presses();
        press_order_service();
        flush_and_recovery();
        door_grant_rules();
        random_traffic();

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/elevator_request_top.sv ====
`timescale 1ns/1ns

module elevator_request_top #(
    parameter int NUM_FLOORS = 11
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic [NUM_FLOORS-1:0]      call_buttons,
    input  logic [NUM_FLOORS-1:0]      panel_buttons,
    input  logic                       door_open_button,
    input  logic                       door_close_button,
    input  logic                       emergency,
    input  logic                       power_on,
    input  elevator_pkg::car_status_t  car_status,
    output logic [NUM_FLOORS-1:0]      call_lamps,
    output logic [NUM_FLOORS-1:0]      panel_lamps,
    output elevator_pkg::car_command_t command,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    import elevator_pkg::*;

    logic         flush;
    floor_event_t push;
    floor_event_t serve;
    floor_t       head;
    logic         empty;

    // Lamps and new request detection
    request_register #(
        .NUM_FLOORS (NUM_FLOORS)
    ) request_register_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .current_floor (car_status.floor),
        .flush         (flush),
        .serve         (serve),
        .push          (push),
        .call_lamps    (call_lamps),
        .panel_lamps   (panel_lamps)
    );

    // Pending floors in arrival order
    floor_queue #(
        .NUM_FLOORS (NUM_FLOORS)
    ) floor_queue_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .flush   (flush),
        .push    (push),
        .serve   (serve),
        .head    (head),
        .empty   (empty)
    );

    car_command_unit car_command_unit_inst (
        .power_on           (power_on),
        .emergency          (emergency),
        .car_status         (car_status),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .head               (head),
        .empty              (empty),
        .flush              (flush),
        .serve              (serve),
        .command            (command),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// ==== verilog/car_command_unit.sv ====
`timescale 1ns/1ns

module car_command_unit (
    input  logic                       power_on,
    input  logic                       emergency,
    input  elevator_pkg::car_status_t  car_status,
    input  logic                       door_open_button,
    input  logic                       door_close_button,
    input  elevator_pkg::floor_t       head,
    input  logic                       empty,
    output logic                       flush,
    output elevator_pkg::floor_event_t serve,
    output elevator_pkg::car_command_t command,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    import elevator_pkg::*;

    logic stopped;
    logic door_ready;
    logic car_ready;
    logic pending;
    logic at_head;

    ////////////////////////////////////////
    // Car condition
    ////////////////////////////////////////

    // Power loss or emergency drops every request
    assign flush = !power_on || emergency;

    assign stopped    = is_stopped(car_status.phase);
    assign door_ready = stopped && power_on;
    assign car_ready  = stopped && !flush;

    // Stopped, powered, no emergency, and something to do
    assign pending = car_ready && !empty;
    assign at_head = (head == car_status.floor);

    ////////////////////////////////////////
    // Serve strobe and travel command
    ////////////////////////////////////////

    always_comb begin
        serve   = '0;
        command = '0;
        if (pending && at_head) begin
            // Car is at the oldest request
            serve.valid = 1'b1;
            serve.floor = head;
        end
        if (pending && !at_head) begin
            command.activate = 1'b1;
            command.up       = (head > car_status.floor);
            command.target   = head;
        end
    end

    ////////////////////////////////////////
    // Door grants
    ////////////////////////////////////////

    assign door_open_allowed  = door_open_button && door_ready;
    assign door_close_allowed = door_close_button && door_ready;

endmodule

// ==== verilog/floor_queue.sv ====
`timescale 1ns/1ns

module floor_queue #(
    parameter int NUM_FLOORS = 11
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       flush,
    input  elevator_pkg::floor_event_t push,
    input  elevator_pkg::floor_event_t serve,
    output elevator_pkg::floor_t       head,
    output logic                       empty
);

    import elevator_pkg::*;

    localparam int PTR_W = $clog2(NUM_FLOORS);
    localparam int CNT_W = $clog2(NUM_FLOORS + 1);

    floor_t           slots [NUM_FLOORS];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;
    logic             full;

    // Circular pointer step
    function automatic logic [PTR_W-1:0] advance(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(NUM_FLOORS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push.valid && !flush;
    assign do_pop  = serve.valid && !flush;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(NUM_FLOORS));
    assign head  = slots[rd_ptr];

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            slots[wr_ptr] <= push.floor;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= advance(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= advance(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Lamps keep duplicates out, so the queue can hold every floor at most once
    no_push_when_full: assert property (
        @(posedge clock) disable iff (!reset_n)
        push.valid |-> !full
    ) else $error("push into a full floor queue");

    // Serve must name the floor that the queue offered
    no_serve_when_empty: assert property (
        @(posedge clock) disable iff (!reset_n)
        serve.valid |-> (!empty && serve.floor == head)
    ) else $error("serve while empty or for a floor other than head");

endmodule

// ==== verilog/request_register.sv ====
`timescale 1ns/1ns

module request_register #(
    parameter int NUM_FLOORS = 11
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic [NUM_FLOORS-1:0]      call_buttons,
    input  logic [NUM_FLOORS-1:0]      panel_buttons,
    input  elevator_pkg::floor_t       current_floor,
    input  logic                       flush,
    input  elevator_pkg::floor_event_t serve,
    output elevator_pkg::floor_event_t push,
    output logic [NUM_FLOORS-1:0]      call_lamps,
    output logic [NUM_FLOORS-1:0]      panel_lamps
);

    import elevator_pkg::*;

    logic [NUM_FLOORS-1:0] lit;
    logic [NUM_FLOORS-1:0] eligible;
    logic                  found;
    floor_t                pick;
    logic [NUM_FLOORS-1:0] pick_mask;
    logic [NUM_FLOORS-1:0] serve_mask;
    logic [NUM_FLOORS-1:0] call_next;
    logic [NUM_FLOORS-1:0] panel_next;

    // A floor with either lamp on is already queued
    assign lit = call_lamps | panel_lamps;

    ////////////////////////////////////////
    // New request detection
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_FLOORS; i++) begin
            eligible[i] = (call_buttons[i] || panel_buttons[i])
                          && !lit[i]
                          && (floor_t'(i) != current_floor);
        end
    end

    // Lowest eligible floor wins, one per cycle
    always_comb begin
        found = 1'b0;
        pick  = '0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                found = 1'b1;
                pick  = floor_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FLOORS; i++) begin
            pick_mask[i]  = found && (pick == floor_t'(i));
            serve_mask[i] = serve.valid && (serve.floor == floor_t'(i));
        end
    end

    ////////////////////////////////////////
    // Lamp update
    ////////////////////////////////////////

    // Presses on lit floors refresh their lamp; the picked floor lights too
    // Serve clears the car's own floor last, so it wins
    assign call_next  = (call_lamps | (call_buttons & (lit | pick_mask))) & ~serve_mask;
    assign panel_next = (panel_lamps | (panel_buttons & (lit | pick_mask))) & ~serve_mask;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lamps  <= '0;
            panel_lamps <= '0;
            push        <= '0;
        end else if (flush) begin
            call_lamps  <= '0;
            panel_lamps <= '0;
            push        <= '0;
        end else begin
            call_lamps  <= call_next;
            panel_lamps <= panel_next;
            push.valid  <= found;
            push.floor  <= pick;
        end
    end

    // The car must never be asked to go where it already stood at the press
    push_not_current_floor: assert property (
        @(posedge clock) disable iff (!reset_n)
        push.valid |-> (push.floor != $past(current_floor))
    ) else $error("push carries the floor the car was on when it was pressed");

endmodule

// ==== verilog/elevator_pkg.sv ====
package elevator_pkg;

    ////////////////////////////////////////
    // Floor numbering
    ////////////////////////////////////////

    // Largest building that a floor number can address
    localparam int MAX_FLOORS = 16;

    // Zero-based floor number
    typedef logic [$clog2(MAX_FLOORS)-1:0] floor_t;

    ////////////////////////////////////////
    // Car status
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        PHASE_STOPPED   = 2'd0,
        PHASE_UP        = 2'd1,
        PHASE_DOWN      = 2'd2,
        PHASE_EMERGENCY = 2'd3
    } car_phase_t;

    // Where the car is and what it is doing
    typedef struct packed {
        floor_t     floor;
        car_phase_t phase;
    } car_status_t;

    ////////////////////////////////////////
    // Strobes and commands
    ////////////////////////////////////////

    // One-cycle strobe with a floor, used for push and serve
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_event_t;

    // Travel request to the car
    typedef struct packed {
        logic   activate;
        logic   up;
        floor_t target;
    } car_command_t;

    function automatic logic is_stopped(input car_phase_t phase);
        return phase == PHASE_STOPPED;
    endfunction

endpackage
